/* logic/apb_bus_pkg.sv */
// APB bus side types

`include "mc_defines.svh"

package apb_bus_pkg;

  // raw bus request, one sample per cycle
  typedef struct packed {
    logic                   sel;
    logic                   enable;
    logic                   write;
    logic [`MC_ADDR_W-1:0]  addr;
    logic [`MC_DATA_W-1:0]  wdata;
    logic [`MC_STRB_W-1:0]  strb;
  } apb_req_t;

  // decoded register access
  typedef struct packed {
    mc_regs_pkg::reg_sel_e  sel;        // which word
    logic                   wr;         // access phase write
    logic                   rd_setup;   // read, setup phase
    logic                   rd_clear;   // read, access phase
    logic [`MC_STRB_W-1:0]  strb;
    logic [`MC_DATA_W-1:0]  wdata;
  } reg_access_t;

endpackage

/* logic/apb_decode.sv */
// APB phase and address decode

`timescale 1ns/1ps

`include "mc_defines.svh"

module apb_decode (
  input  logic                     pclk_i,
  input  logic                     prst_ni,
  input  apb_bus_pkg::apb_req_t    apb_i,
  output apb_bus_pkg::reg_access_t acc_o
);

  logic [`MC_ADDR_W-1:0]  word_addr;
  mc_regs_pkg::reg_sel_e  sel;
  logic                   rd_setup;
  logic                   setup_rd_q;    // last cycle was a read setup

  assign word_addr = {apb_i.addr[`MC_ADDR_W-1:2], 2'b00};  // byte offset dropped

  always_comb
  begin
    case (word_addr)
      `MC_ADDR_MR:     sel = mc_regs_pkg::SEL_MR;
      `MC_ADDR_TRAIN:  sel = mc_regs_pkg::SEL_TRAIN;
      `MC_ADDR_CTRL:   sel = mc_regs_pkg::SEL_CTRL;
      `MC_ADDR_MR4DIS: sel = mc_regs_pkg::SEL_MR4DIS;
      `MC_ADDR_MR4INT: sel = mc_regs_pkg::SEL_MR4INT;
      `MC_ADDR_ISTAT:  sel = mc_regs_pkg::SEL_ISTAT;
      `MC_ADDR_IEN:    sel = mc_regs_pkg::SEL_IEN;
      default:         sel = mc_regs_pkg::SEL_NONE;  // unmapped
    endcase
  end

  assign rd_setup = apb_i.sel & ~apb_i.enable & ~apb_i.write;

  // clear only follows a setup that loaded prdata
  always_ff @(posedge pclk_i or negedge prst_ni)
  begin
    if (!prst_ni)
      setup_rd_q <= 1'b0;
    else
      setup_rd_q <= rd_setup;
  end

  always_comb
  begin
    acc_o.sel      = sel;
    acc_o.wr       = apb_i.sel & apb_i.enable & apb_i.write;
    acc_o.rd_setup = rd_setup;
    acc_o.rd_clear = apb_i.sel & apb_i.enable & ~apb_i.write & setup_rd_q;
    acc_o.strb     = apb_i.strb;
    acc_o.wdata    = apb_i.wdata;
  end

endmodule

/* logic/mc_apb_regs.sv */
// LPDDR MC APB register slave

`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_apb_regs (
  input  logic                    pclk_i,
  input  logic                    prst_ni,
  input  logic [`MC_ADDR_W-1:0]   paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`MC_DATA_W-1:0]   pwdata_i,
  input  logic [`MC_STRB_W-1:0]   pstrb_i,
  output logic                    pready_o,
  output logic [`MC_DATA_W-1:0]   prdata_o,
  output logic [`MC_NB_RANK-1:0]  rank_mrw_o,
  output logic [`MC_NB_RANK-1:0]  rank_mrr_o,
  input  logic [`MC_NB_RANK-1:0]  mrw_done_i,
  input  logic [`MC_NB_RANK-1:0]  mrr_done_i,
  output mc_regs_pkg::train_t     train_start_o,
  input  mc_regs_pkg::train_t     train_done_i,
  input  logic                    mc_ready_i,
  output logic                    traffic_en_o,
  input  mc_regs_pkg::mc_err_t    err_i,
  output logic                    mc_intr_o,
  output logic                    mr4_rd_pulse_o
);

  apb_bus_pkg::apb_req_t      apb_req;
  apb_bus_pkg::reg_access_t   acc;
  mc_regs_pkg::bank_view_t    bank_view;
  mc_regs_pkg::irq_view_t     irq_view;
  logic                       mr4_disable;
  logic [`MC_MR4_INT_W-1:0]   mr4_interval;

  assign pready_o = psel_i;           // zero wait states

  assign apb_req = '{sel: psel_i, enable: penable_i, write: pwrite_i,
                     addr: paddr_i, wdata: pwdata_i, strb: pstrb_i};

  apb_decode u_decode (
    .pclk_i  (pclk_i),
    .prst_ni (prst_ni),
    .apb_i   (apb_req),
    .acc_o   (acc)
  );

  mc_reg_bank u_bank (
    .pclk_i         (pclk_i),
    .prst_ni        (prst_ni),
    .acc_i          (acc),
    .mrw_done_i     (mrw_done_i),
    .mrr_done_i     (mrr_done_i),
    .train_done_i   (train_done_i),
    .mc_ready_i     (mc_ready_i),
    .rank_mrw_o     (rank_mrw_o),
    .rank_mrr_o     (rank_mrr_o),
    .train_start_o  (train_start_o),
    .traffic_en_o   (traffic_en_o),
    .rank_index_o   (),           // index reaches the read path through view_o
    .mr4_disable_o  (mr4_disable),
    .mr4_interval_o (mr4_interval),
    .view_o         (bank_view)
  );

  mc_status_irq u_irq (
    .pclk_i     (pclk_i),
    .prst_ni    (prst_ni),
    .acc_i      (acc),
    .mrw_done_i (mrw_done_i),
    .mrr_done_i (mrr_done_i),
    .err_i      (err_i),
    .view_o     (irq_view),
    .mc_intr_o  (mc_intr_o)
  );

  mc_mr4_timer u_mr4 (
    .pclk_i         (pclk_i),
    .prst_ni        (prst_ni),
    .disable_i      (mr4_disable),
    .interval_i     (mr4_interval),
    .mr4_rd_pulse_o (mr4_rd_pulse_o)
  );

  mc_read_result u_rdata (
    .pclk_i   (pclk_i),
    .prst_ni  (prst_ni),
    .acc_i    (acc),
    .bank_i   (bank_view),
    .irq_i    (irq_view),
    .prdata_o (prdata_o)
  );

endmodule

/* logic/mc_defines.svh */
// LPDDR MC register slave
// widths and register map
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

`define MC_ADDR_W       16             // apb address bits
`define MC_DATA_W       32             // apb data bits
`define MC_STRB_W       (`MC_DATA_W / 8)
`define MC_NB_RANK      2
`define MC_RANK_IDX_W   3              // rank index register width
`define MC_MR4_INT_W    6
`define MC_MR4_CNT_W    8              // holds max interval * factor

// word addresses
`define MC_ADDR_MR      16'h0000       // mode register access
`define MC_ADDR_TRAIN   16'h0010
`define MC_ADDR_CTRL    16'h0014
`define MC_ADDR_MR4DIS  16'h0018
`define MC_ADDR_MR4INT  16'h0040
`define MC_ADDR_ISTAT   16'h0060       // clear on read
`define MC_ADDR_IEN     16'h0064

`define MC_MR4_INT_RST  6'd2
`define MC_MR4_FACTOR   2              // pulse interval / pulse width

`endif

/* logic/mc_mr4_timer.sv */
// MR4 read pulse timer

`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_mr4_timer (
  input  logic                      pclk_i,
  input  logic                      prst_ni,
  input  logic                      disable_i,
  input  logic [`MC_MR4_INT_W-1:0]  interval_i,
  output logic                      mr4_rd_pulse_o
);

  localparam int CNT_W = `MC_MR4_CNT_W;
  localparam logic [CNT_W-1:0] FACTOR = CNT_W'(`MC_MR4_FACTOR);

  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] limit;
  logic             hit;

  assign limit = CNT_W'(interval_i) * FACTOR;
  assign hit   = count_q >= limit;      // >= so a smaller new interval wraps at once

  always_ff @(posedge pclk_i or negedge prst_ni)
  begin
    if (!prst_ni)
      count_q <= '0;
    else if (disable_i | hit)
      count_q <= '0;                    // held at zero while disabled
    else
      count_q <= count_q + 1'b1;
  end

  assign mr4_rd_pulse_o = hit & ~disable_i;

endmodule

/* logic/mc_read_result.sv */
// read data mux and prdata register

`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_read_result (
  input  logic                      pclk_i,
  input  logic                      prst_ni,
  input  apb_bus_pkg::reg_access_t  acc_i,
  input  mc_regs_pkg::bank_view_t   bank_i,
  input  mc_regs_pkg::irq_view_t    irq_i,
  output logic [`MC_DATA_W-1:0]     prdata_o
);

  logic [`MC_DATA_W-1:0] rd_word;
  logic [`MC_DATA_W-1:0] prdata_q;

  //////////////////////////////////////////////////
  // byte lane layout per word
  always_comb
  begin
    rd_word = '0;
    case (acc_i.sel)
      mc_regs_pkg::SEL_MR:
      begin
        rd_word[7:0]   = bank_i.rank.mr_addr;
        rd_word[15:8]  = bank_i.rank.mr_data;
        rd_word[18]    = bank_i.rank.busy;
        rd_word[21]    = bank_i.rank.mrw_done;
        rd_word[22]    = bank_i.rank.mrr_done;
        rd_word[26:24] = bank_i.rank.rank_index;
      end
      mc_regs_pkg::SEL_TRAIN:  rd_word[6:0] = bank_i.train_busy;
      mc_regs_pkg::SEL_CTRL:
      begin
        rd_word[0] = bank_i.mc_ready;
        rd_word[7] = bank_i.traffic_en;
      end
      mc_regs_pkg::SEL_MR4DIS: rd_word[11] = bank_i.mr4_disable;
      mc_regs_pkg::SEL_MR4INT: rd_word[`MC_MR4_INT_W-1:0] = bank_i.mr4_interval;
      mc_regs_pkg::SEL_ISTAT:
      begin
        rd_word[`MC_NB_RANK-1:0] = irq_i.rank_stat;
        rd_word[14:8]            = irq_i.err_stat;
      end
      mc_regs_pkg::SEL_IEN:
      begin
        rd_word[`MC_NB_RANK-1:0] = irq_i.rank_en;
        rd_word[14:8]            = irq_i.err_en;
      end
      default: rd_word = '0;          // unmapped reads zero
    endcase
  end

  // loaded in setup, stable through the access phase
  always_ff @(posedge pclk_i or negedge prst_ni)
  begin
    if (!prst_ni)
      prdata_q <= '0;
    else if (acc_i.rd_setup)
      prdata_q <= rd_word;
  end

  assign prdata_o = prdata_q;

endmodule

/* logic/mc_reg_bank.sv */
// MC control register bank

`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_reg_bank (
  input  logic                            pclk_i,
  input  logic                            prst_ni,
  input  apb_bus_pkg::reg_access_t        acc_i,
  input  logic [`MC_NB_RANK-1:0]          mrw_done_i,
  input  logic [`MC_NB_RANK-1:0]          mrr_done_i,
  input  mc_regs_pkg::train_t             train_done_i,
  input  logic                            mc_ready_i,
  output logic [`MC_NB_RANK-1:0]          rank_mrw_o,
  output logic [`MC_NB_RANK-1:0]          rank_mrr_o,
  output mc_regs_pkg::train_t             train_start_o,
  output logic                            traffic_en_o,
  output logic [`MC_RANK_IDX_W-1:0]       rank_index_o,
  output logic                            mr4_disable_o,
  output logic [`MC_MR4_INT_W-1:0]        mr4_interval_o,
  output mc_regs_pkg::bank_view_t         view_o
);

  localparam int RANK_W = (`MC_NB_RANK > 1) ? $clog2(`MC_NB_RANK) : 1;

  logic [`MC_NB_RANK-1:0][7:0]  mr_addr_q;
  logic [`MC_NB_RANK-1:0][7:0]  mr_data_q;
  logic [`MC_RANK_IDX_W-1:0]    rank_index_q;
  logic [`MC_NB_RANK-1:0]       mrw_q, mrr_q, busy_q;
  logic [`MC_NB_RANK-1:0]       mrw_done_q, mrr_done_q;
  logic [6:0]                   train_start_q, train_busy_q;
  logic                         mc_ready_q, traffic_q, mr4_dis_q;
  logic [`MC_MR4_INT_W-1:0]     mr4_int_q;

  logic                         wr_mr, idx_ok;
  logic [RANK_W-1:0]            rank_sel;
  logic [`MC_NB_RANK-1:0]       rank_hit, mrw_req, mrr_req, done_clr;
  logic [6:0]                   train_req;

  assign wr_mr    = acc_i.wr & (acc_i.sel == mc_regs_pkg::SEL_MR);
  assign idx_ok   = rank_index_q < `MC_RANK_IDX_W'(`MC_NB_RANK);  // no such rank otherwise
  assign rank_sel = rank_index_q[RANK_W-1:0];

  always_comb
  begin
    rank_hit = '0;
    if (idx_ok)
      rank_hit[rank_sel] = 1'b1;
  end

  assign mrw_req  = {`MC_NB_RANK{wr_mr & acc_i.strb[2] & acc_i.wdata[16]}} & rank_hit;
  assign mrr_req  = {`MC_NB_RANK{wr_mr & acc_i.strb[2] & acc_i.wdata[17]}} & rank_hit;
  assign done_clr = {`MC_NB_RANK{acc_i.rd_clear & (acc_i.sel == mc_regs_pkg::SEL_MR)}}
                    & rank_hit;
  assign train_req = (acc_i.wr & acc_i.strb[0] & (acc_i.sel == mc_regs_pkg::SEL_TRAIN)) ?
                     acc_i.wdata[6:0] : 7'd0;

  //////////////////////////////////////////////////
  // registers
  always_ff @(posedge pclk_i or negedge prst_ni)
  begin
    if (!prst_ni)
    begin
      mr_addr_q     <= '0;
      mr_data_q     <= '0;
      rank_index_q  <= '0;
      mrw_q         <= '0;
      mrr_q         <= '0;
      busy_q        <= '0;
      mrw_done_q    <= '0;
      mrr_done_q    <= '0;
      train_start_q <= '0;
      train_busy_q  <= '0;
      mc_ready_q    <= 1'b0;
      traffic_q     <= 1'b0;
      mr4_dis_q     <= 1'b0;
      mr4_int_q     <= `MC_MR4_INT_RST;
    end
    else
    begin
      if (wr_mr & acc_i.strb[0] & idx_ok)
        mr_addr_q[rank_sel] <= acc_i.wdata[7:0];
      if (wr_mr & acc_i.strb[1] & idx_ok)
        mr_data_q[rank_sel] <= acc_i.wdata[15:8];
      if (wr_mr & acc_i.strb[3])
        rank_index_q <= acc_i.wdata[26:24];   // takes effect after this write

      mrw_q      <= mrw_req;                  // one cycle request pulses
      mrr_q      <= mrr_req;
      busy_q     <= mrw_req | mrr_req | (busy_q & ~(mrw_done_i | mrr_done_i));
      mrw_done_q <= mrw_done_i | (mrw_done_q & ~done_clr);  // set beats clear
      mrr_done_q <= mrr_done_i | (mrr_done_q & ~done_clr);

      train_start_q <= train_req;
      train_busy_q  <= train_req | (train_busy_q & ~train_done_i);

      mc_ready_q <= mc_ready_i;
      if (acc_i.wr & acc_i.strb[0] & (acc_i.sel == mc_regs_pkg::SEL_CTRL))
        traffic_q <= acc_i.wdata[7];
      if (acc_i.wr & acc_i.strb[1] & (acc_i.sel == mc_regs_pkg::SEL_MR4DIS))
        mr4_dis_q <= acc_i.wdata[11];
      if (acc_i.wr & acc_i.strb[0] & (acc_i.sel == mc_regs_pkg::SEL_MR4INT))
        mr4_int_q <= acc_i.wdata[`MC_MR4_INT_W-1:0];
    end
  end

  assign rank_mrw_o     = mrw_q;
  assign rank_mrr_o     = mrr_q;
  assign train_start_o  = mc_regs_pkg::train_t'(train_start_q);
  assign traffic_en_o   = traffic_q;
  assign rank_index_o   = rank_index_q;
  assign mr4_disable_o  = mr4_dis_q;
  assign mr4_interval_o = mr4_int_q;

  // read side view, out of range index reads zero
  always_comb
  begin
    view_o = '0;
    if (idx_ok)
    begin
      view_o.rank.mr_addr  = mr_addr_q[rank_sel];
      view_o.rank.mr_data  = mr_data_q[rank_sel];
      view_o.rank.busy     = busy_q[rank_sel];
      view_o.rank.mrw_done = mrw_done_q[rank_sel];
      view_o.rank.mrr_done = mrr_done_q[rank_sel];
    end
    view_o.rank.rank_index = rank_index_q;
    view_o.train_busy      = mc_regs_pkg::train_t'(train_busy_q);
    view_o.mc_ready        = mc_ready_q;
    view_o.traffic_en      = traffic_q;
    view_o.mr4_disable     = mr4_dis_q;
    view_o.mr4_interval    = mr4_int_q;
  end

endmodule

/* logic/mc_regs_pkg.sv */
// MC register map types

`include "mc_defines.svh"

package mc_regs_pkg;

  // register select, doubles as the access opcode
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_MR,
    SEL_TRAIN,
    SEL_CTRL,
    SEL_MR4DIS,
    SEL_MR4INT,
    SEL_ISTAT,
    SEL_IEN
  } reg_sel_e;

  // training types, ca at bit 0
  typedef struct packed {
    logic all;
    logic zq;
    logic rd_gate;
    logic rd_lvl;
    logic wr_lvl;
    logic wr_dq;
    logic ca;
  } train_t;

  // error sources, init at bit 0
  typedef struct packed {
    logic mc;
    logic wr_dq;
    logic wr_lvl;
    logic rd_lvl;
    logic rd_gate;
    logic ca;
    logic init;
  } mc_err_t;

  typedef struct packed {
    logic [7:0]                 mr_addr;
    logic [7:0]                 mr_data;
    logic                       busy;
    logic                       mrw_done;
    logic                       mrr_done;
    logic [`MC_RANK_IDX_W-1:0]  rank_index;
  } rank_view_t;

  typedef struct packed {
    rank_view_t                 rank;        // selected rank only
    train_t                     train_busy;
    logic                       mc_ready;
    logic                       traffic_en;
    logic                       mr4_disable;
    logic [`MC_MR4_INT_W-1:0]   mr4_interval;
  } bank_view_t;

  typedef struct packed {
    logic [`MC_NB_RANK-1:0]     rank_stat;
    logic [`MC_NB_RANK-1:0]     rank_en;
    mc_err_t                    err_stat;
    mc_err_t                    err_en;
  } irq_view_t;

endpackage

/* logic/mc_status_irq.sv */
// interrupt status and enables

`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_status_irq (
  input  logic                      pclk_i,
  input  logic                      prst_ni,
  input  apb_bus_pkg::reg_access_t  acc_i,
  input  logic [`MC_NB_RANK-1:0]    mrw_done_i,
  input  logic [`MC_NB_RANK-1:0]    mrr_done_i,
  input  mc_regs_pkg::mc_err_t      err_i,
  output mc_regs_pkg::irq_view_t    view_o,
  output logic                      mc_intr_o
);

  logic [`MC_NB_RANK-1:0] rank_stat_q, rank_en_q;
  logic [6:0]             err_stat_q, err_en_q;
  logic                   stat_clr, wr_ien;

  assign stat_clr = acc_i.rd_clear & (acc_i.sel == mc_regs_pkg::SEL_ISTAT);
  assign wr_ien   = acc_i.wr & (acc_i.sel == mc_regs_pkg::SEL_IEN);

  always_ff @(posedge pclk_i or negedge prst_ni)
  begin
    if (!prst_ni)
    begin
      rank_stat_q <= '0;
      err_stat_q  <= '0;
      rank_en_q   <= '1;                 // all sources enabled
      err_en_q    <= '1;
    end
    else
    begin
      // new event in the clearing cycle survives
      rank_stat_q <= mrw_done_i | mrr_done_i | (rank_stat_q & ~{`MC_NB_RANK{stat_clr}});
      err_stat_q  <= err_i | (err_stat_q & ~{7{stat_clr}});
      if (wr_ien & acc_i.strb[0])
        rank_en_q <= acc_i.wdata[`MC_NB_RANK-1:0];
      if (wr_ien & acc_i.strb[1])
        err_en_q  <= acc_i.wdata[14:8];
    end
  end

  assign mc_intr_o = (|(rank_stat_q & rank_en_q)) | (|(err_stat_q & err_en_q));

  always_comb
  begin
    view_o.rank_stat = rank_stat_q;
    view_o.rank_en   = rank_en_q;
    view_o.err_stat  = mc_regs_pkg::mc_err_t'(err_stat_q);
    view_o.err_en    = mc_regs_pkg::mc_err_t'(err_en_q);
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the MC APB register testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_mc_apb_regs \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
  exit 0
fi
exit 1

/* testbench/mc_reg_checker.sv */
// MC register checker
// shadow model and read compare

`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_reg_checker (
  input  logic                    pclk_i,
  input  logic                    prst_ni,
  input  logic [`MC_ADDR_W-1:0]   paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`MC_DATA_W-1:0]   pwdata_i,
  input  logic [`MC_STRB_W-1:0]   pstrb_i,
  input  logic                    pready_i,
  input  logic [`MC_DATA_W-1:0]   prdata_i,
  input  logic [`MC_NB_RANK-1:0]  rank_mrw_i,
  input  logic [`MC_NB_RANK-1:0]  rank_mrr_i,
  input  logic [`MC_NB_RANK-1:0]  mrw_done_i,
  input  logic [`MC_NB_RANK-1:0]  mrr_done_i,
  input  logic [6:0]              train_start_i,
  input  logic [6:0]              train_done_i,
  input  logic                    mc_ready_i,
  input  logic                    traffic_en_i,
  input  logic [6:0]              err_i,
  input  logic                    mc_intr_i,
  input  logic                    mr4_rd_pulse_i
);

  logic [7:0]              m_addr [`MC_NB_RANK];
  logic [7:0]              m_data [`MC_NB_RANK];
  logic [2:0]              m_idx;
  logic [`MC_NB_RANK-1:0]  m_busy, m_wdone, m_rdone, m_rstat, m_ren;
  logic [`MC_NB_RANK-1:0]  exp_mrw, exp_mrr, done_clr;
  logic [6:0]              m_tbusy, m_estat, m_een, exp_train;
  logic                    m_ready, m_traffic, m_dis, last_dis;
  logic [5:0]              m_int, last_int;
  logic [15:0]             word;
  logic                    wr, clr, sclr, setup_seen, idx_ok, have_pulse;
  logic [31:0]             rd_exp;
  int                      ri, rd_seq, rd_seen, cycle, last_cycle;
  int                      value_errors = 0;
  int                      event_errors = 0;
  int                      reads_checked = 0;
  int                      gaps_rst = 0;
  int                      gaps_new = 0;

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    begin
      $display("[ERROR] %0d ns %s: got %h expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // expected read word from the register map
  function automatic logic [31:0] expected_word(input logic [15:0] addr);
    logic [31:0] w;
    int          r;
    begin
      w = '0;
      r = m_idx;
      case (addr)
        `MC_ADDR_MR:
        begin
          if (r < `MC_NB_RANK)
          begin
            w[7:0]  = m_addr[r];
            w[15:8] = m_data[r];
            w[18]   = m_busy[r];
            w[21]   = m_wdone[r];
            w[22]   = m_rdone[r];
          end
          w[26:24] = m_idx;
        end
        `MC_ADDR_TRAIN:  w[6:0] = m_tbusy;
        `MC_ADDR_CTRL:   w = {24'd0, m_traffic, 6'd0, m_ready};
        `MC_ADDR_MR4DIS: w[11] = m_dis;
        `MC_ADDR_MR4INT: w[5:0] = m_int;
        `MC_ADDR_ISTAT:  w = {17'd0, m_estat, 6'd0, m_rstat};
        `MC_ADDR_IEN:    w = {17'd0, m_een, 6'd0, m_ren};
        default:         w = '0;                 // unmapped word
      endcase
      return w;
    end
  endfunction

  //////////////////////////////////////////////////
  // shadow model updated on every clock edge
  always @(posedge pclk_i or negedge prst_ni)
  begin
    if (!prst_ni)
    begin
      m_addr     = '{default: 8'd0};
      m_data     = '{default: 8'd0};
      m_idx      = '0;
      m_busy     = '0;
      m_wdone    = '0;
      m_rdone    = '0;
      m_rstat    = '0;
      m_estat    = '0;
      m_ren      = '1;
      m_een      = '1;
      m_tbusy    = '0;
      m_ready    = 1'b0;
      m_traffic  = 1'b0;
      m_dis      = 1'b0;
      m_int      = `MC_MR4_INT_RST;
      exp_mrw    = '0;
      exp_mrr    = '0;
      exp_train  = '0;
      setup_seen = 1'b0;
    end
    else
    begin
      if (pready_i !== psel_i)                 // psel_i is stable at this edge
        flag_mismatch("pready_o", pready_i, psel_i);
      word = {paddr_i[15:2], 2'b00};
      wr   = psel_i & penable_i & pwrite_i;
      clr  = psel_i & penable_i & ~pwrite_i & setup_seen;  // access after read setup
      setup_seen = psel_i & ~penable_i & ~pwrite_i;
      if (setup_seen)
      begin
        rd_exp = expected_word(word);          // state before this edge
        rd_seq++;
      end
      idx_ok   = m_idx < `MC_NB_RANK;
      ri       = m_idx;
      exp_mrw  = '0;
      exp_mrr  = '0;
      done_clr = '0;
      if (wr && word == `MC_ADDR_MR && pstrb_i[2] && idx_ok)
      begin
        exp_mrw[ri] = pwdata_i[16];
        exp_mrr[ri] = pwdata_i[17];
      end
      if (clr && word == `MC_ADDR_MR && idx_ok)
        done_clr[ri] = 1'b1;
      m_busy  = exp_mrw | exp_mrr | (m_busy & ~(mrw_done_i | mrr_done_i));
      m_wdone = mrw_done_i | (m_wdone & ~done_clr);
      m_rdone = mrr_done_i | (m_rdone & ~done_clr);
      if (wr && word == `MC_ADDR_MR && idx_ok && pstrb_i[0])
        m_addr[ri] = pwdata_i[7:0];
      if (wr && word == `MC_ADDR_MR && idx_ok && pstrb_i[1])
        m_data[ri] = pwdata_i[15:8];
      if (wr && word == `MC_ADDR_MR && pstrb_i[3])
        m_idx = pwdata_i[26:24];               // new index after the lane writes
      exp_train = (wr && word == `MC_ADDR_TRAIN && pstrb_i[0]) ? pwdata_i[6:0] : 7'd0;
      m_tbusy   = exp_train | (m_tbusy & ~train_done_i);
      m_ready   = mc_ready_i;
      if (wr && word == `MC_ADDR_CTRL && pstrb_i[0])
        m_traffic = pwdata_i[7];
      if (wr && word == `MC_ADDR_MR4DIS && pstrb_i[1])
        m_dis = pwdata_i[11];
      if (wr && word == `MC_ADDR_MR4INT && pstrb_i[0])
        m_int = pwdata_i[5:0];
      sclr    = clr && word == `MC_ADDR_ISTAT;
      m_rstat = mrw_done_i | mrr_done_i | (sclr ? '0 : m_rstat);  // event beats clear
      m_estat = err_i | (sclr ? '0 : m_estat);
      if (wr && word == `MC_ADDR_IEN && pstrb_i[0])
        m_ren = pwdata_i[`MC_NB_RANK-1:0];
      if (wr && word == `MC_ADDR_IEN && pstrb_i[1])
        m_een = pwdata_i[14:8];
    end
  end

  //////////////////////////////////////////////////
  // compare on the falling edge where outputs are settled
  always @(negedge pclk_i)
  begin
    if (!prst_ni)
    begin
      have_pulse = 1'b0;
      last_dis   = 1'b0;
      last_int   = `MC_MR4_INT_RST;
      rd_seen    = rd_seq;
    end
    else
    begin
      cycle++;
      if (rd_seen != rd_seq)
      begin
        rd_seen = rd_seq;
        reads_checked++;
        if (prdata_i !== rd_exp)
          flag_mismatch("prdata_o", prdata_i, rd_exp);
      end
      if (rank_mrw_i !== exp_mrw)
        flag_mismatch("rank_mrw_o", rank_mrw_i, exp_mrw);
      if (rank_mrr_i !== exp_mrr)
        flag_mismatch("rank_mrr_o", rank_mrr_i, exp_mrr);
      if (train_start_i !== exp_train)
        flag_mismatch("train_start_o", train_start_i, exp_train);
      if (traffic_en_i !== m_traffic)
        flag_mismatch("traffic_en_o", traffic_en_i, m_traffic);
      if (mc_intr_i !== ((|(m_rstat & m_ren)) | (|(m_estat & m_een))))
        flag_mismatch("mc_intr_o", mc_intr_i, (|(m_rstat & m_ren)) | (|(m_estat & m_een)));
      if (m_dis !== last_dis || m_int !== last_int)
        have_pulse = 1'b0;                     // gap spans an interval or disable change
      last_dis = m_dis;
      last_int = m_int;
      if (mr4_rd_pulse_i === 1'b1)
      begin
        if (m_dis)
        begin
          $display("MR4 read pulse seen at %0d ns while the timer is disabled", $time);
          event_errors++;
        end
        else if (have_pulse)
        begin
          if (cycle - last_cycle != m_int * `MC_MR4_FACTOR + 1)
            flag_mismatch("mr4_rd_pulse_o gap", cycle - last_cycle,
                          m_int * `MC_MR4_FACTOR + 1);
          if (m_int == `MC_MR4_INT_RST)
            gaps_rst++;
          else
            gaps_new++;
        end
        have_pulse = 1'b1;
        last_cycle = cycle;
      end
    end
  end

endmodule

/* testbench/tb_mc_apb_regs.sv */
// MC APB register slave testbench

`timescale 1ns/1ps

`include "mc_defines.svh"

module tb_mc_apb_regs;

  localparam int CLK_PERIOD      = 10;
  localparam int XFER_COUNT      = 110;        // upper bound of the transfers below
  localparam int WATCHDOG_CYCLES = XFER_COUNT * 3 + 200;

  logic                    pclk, prst_n;
  logic [`MC_ADDR_W-1:0]   paddr;
  logic                    psel, penable, pwrite, pready;
  logic [`MC_DATA_W-1:0]   pwdata, prdata, data;
  logic [`MC_STRB_W-1:0]   pstrb;
  logic [`MC_NB_RANK-1:0]  rank_mrw, rank_mrr, mrw_done, mrr_done;
  mc_regs_pkg::train_t     train_start, train_done;
  mc_regs_pkg::mc_err_t    err;
  logic                    mc_ready, traffic_en, mc_intr, mr4_rd_pulse;
  logic [6:0]              bits;
  integer                  seed = 32'hc877_c426;
  int                      r, k, xfers, reads, coverage_errors, total;

  mc_apb_regs DUT (
    .pclk_i (pclk), .prst_ni (prst_n),
    .paddr_i (paddr), .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .pwdata_i (pwdata), .pstrb_i (pstrb), .pready_o (pready), .prdata_o (prdata),
    .rank_mrw_o (rank_mrw), .rank_mrr_o (rank_mrr),
    .mrw_done_i (mrw_done), .mrr_done_i (mrr_done),
    .train_start_o (train_start), .train_done_i (train_done),
    .mc_ready_i (mc_ready), .traffic_en_o (traffic_en), .err_i (err),
    .mc_intr_o (mc_intr), .mr4_rd_pulse_o (mr4_rd_pulse)
  );

  mc_reg_checker u_checker (
    .pclk_i (pclk), .prst_ni (prst_n),
    .paddr_i (paddr), .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .pwdata_i (pwdata), .pstrb_i (pstrb), .pready_i (pready), .prdata_i (prdata),
    .rank_mrw_i (rank_mrw), .rank_mrr_i (rank_mrr),
    .mrw_done_i (mrw_done), .mrr_done_i (mrr_done),
    .train_start_i (train_start), .train_done_i (train_done),
    .mc_ready_i (mc_ready), .traffic_en_i (traffic_en), .err_i (err),
    .mc_intr_i (mc_intr), .mr4_rd_pulse_i (mr4_rd_pulse)
  );

  initial
  begin
    pclk = 1'b0;
    forever #(CLK_PERIOD / 2) pclk = ~pclk;
  end

  task automatic abort_run(input string reason);
    begin
      $display("%s", reason);
      $display(">>> FAIL");
      $finish;
    end
  endtask

  // setup and access phases plus one idle cycle
  task automatic apb_transfer(input logic write, input logic [15:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb);
    int waits;
    begin
      @(negedge pclk);
      paddr   = addr;
      pwrite  = write;
      pwdata  = wdata;
      pstrb   = strb;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge pclk);
      penable = 1'b1;
      waits   = 0;
      @(posedge pclk);
      while (!pready && waits < 8)
      begin
        waits++;
        @(posedge pclk);
      end
      if (!pready)
        abort_run("APB access phase got no pready_o");
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
      xfers++;
      if (!write)
        reads++;
    end
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb);
    apb_transfer(1'b1, addr, wdata, strb);
  endtask

  task automatic apb_read(input logic [15:0] addr);
    apb_transfer(1'b0, addr, 32'd0, 4'd0);
  endtask

  // one cycle of backend events
  task automatic pulse_backend(input logic [1:0] wdone, input logic [1:0] rdone,
                               input logic [6:0] tdone, input logic [6:0] errs);
    begin
      @(negedge pclk);
      mrw_done   = wdone;
      mrr_done   = rdone;
      train_done = mc_regs_pkg::train_t'(tdone);
      err        = mc_regs_pkg::mc_err_t'(errs);
      @(negedge pclk);
      mrw_done   = '0;
      mrr_done   = '0;
      train_done = '0;
      err        = '0;
    end
  endtask

  task automatic wait_mr4_pulses(input int count);
    repeat (count)
    begin
      @(negedge pclk);
      while (mr4_rd_pulse !== 1'b1)
        @(negedge pclk);
    end
  endtask

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before the tests completed");
  end

  initial
  begin
    {paddr, psel, penable, pwrite, pwdata, pstrb} = '0;
    {mrw_done, mrr_done, train_done, err, mc_ready} = '0;
    {xfers, reads, coverage_errors} = '0;
    prst_n = 1'b0;
    repeat (2) @(posedge pclk);
    @(negedge pclk);
    prst_n = 1'b1;

    // MRW then MRR on each rank
    for (r = 0; r < `MC_NB_RANK; r++)
    begin
      apb_write(`MC_ADDR_MR, 32'(r) << 24, 4'b1000);
      for (k = 0; k < 2; k++)
      begin
        apb_write(`MC_ADDR_MR, 32'h1 << (16 + k), 4'b0100);
        apb_read(`MC_ADDR_MR);
        pulse_backend((k == 0) ? 2'(1 << r) : 2'b0, (k == 1) ? 2'(1 << r) : 2'b0, 0, 0);
        apb_read(`MC_ADDR_MR);                   // done seen once
        apb_read(`MC_ADDR_MR);
      end
    end
    apb_read(`MC_ADDR_ISTAT);

    repeat (2)
    begin
      bits = 7'($random(seed)) | 7'h01;
      apb_write(`MC_ADDR_TRAIN, {25'd0, bits}, 4'b0001);
      apb_read(`MC_ADDR_TRAIN);
      pulse_backend(0, 0, bits & 7'h55, 0);      // partial done
      apb_read(`MC_ADDR_TRAIN);
      pulse_backend(0, 0, bits, 0);
      apb_read(`MC_ADDR_TRAIN);
    end

    // interrupts enabled and then masked
    bits = 7'($random(seed)) | 7'h10;
    pulse_backend(0, 0, 0, bits);
    apb_read(`MC_ADDR_ISTAT);
    apb_read(`MC_ADDR_ISTAT);
    apb_write(`MC_ADDR_IEN, 32'd0, 4'b0011);
    pulse_backend(2'b01, 0, 0, bits);
    repeat (3) @(negedge pclk);
    apb_read(`MC_ADDR_IEN);
    apb_read(`MC_ADDR_ISTAT);
    apb_write(`MC_ADDR_IEN, 32'hffff_ffff, 4'b0011);

    for (k = 0; k < 16; k++)
    begin
      r    = $random(seed) & 1;
      data = ($random(seed) & ~32'h0703_0000) | (32'(r) << 24);
      apb_write(`MC_ADDR_MR, 32'(r) << 24, 4'b1000);
      apb_write(`MC_ADDR_MR, data, 4'($random(seed)));
      apb_read(`MC_ADDR_MR);
    end
    for (k = 0; k < 4; k++)
    begin
      apb_write(`MC_ADDR_MR4INT, $random(seed), 4'($random(seed)));
      apb_read(`MC_ADDR_MR4INT);
      apb_write(`MC_ADDR_IEN, $random(seed), 4'($random(seed)));
      apb_read(`MC_ADDR_IEN);
    end
    mc_ready = 1'b1;
    apb_write(`MC_ADDR_CTRL, 32'h80, 4'b0001);
    apb_read(`MC_ADDR_CTRL);
    apb_read(16'h007c);                          // unmapped word

    // MR4 timer with a written interval and then disabled
    apb_write(`MC_ADDR_MR4INT, 32'd3, 4'b0001);
    wait_mr4_pulses(4);
    apb_write(`MC_ADDR_MR4DIS, 32'h800, 4'b0010);
    apb_read(`MC_ADDR_MR4DIS);
    repeat (30) @(negedge pclk);

    if (u_checker.reads_checked != reads || u_checker.gaps_rst < 2 || u_checker.gaps_new < 2)
    begin
      $display("too few reads or MR4 pulse gaps were checked");
      coverage_errors = 1;
    end
    total = u_checker.value_errors + u_checker.event_errors + coverage_errors;
    $display("errors: value %0d, event %0d, coverage %0d (%0d transfers)",
             u_checker.value_errors, u_checker.event_errors, coverage_errors, xfers);
    if (total == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+logic
logic/mc_regs_pkg.sv
logic/apb_bus_pkg.sv
logic/apb_decode.sv
logic/mc_reg_bank.sv
logic/mc_status_irq.sv
logic/mc_mr4_timer.sv
logic/mc_read_result.sv
logic/mc_apb_regs.sv
testbench/mc_reg_checker.sv
testbench/tb_mc_apb_regs.sv
